/* source/board_ctrl_defines.svh */
`ifndef BOARD_CTRL_DEFINES_SVH
`define BOARD_CTRL_DEFINES_SVH

// APB bus widths
`define BOARD_APB_AW 8
`define BOARD_APB_DW 32

// soc_clk cycles per RTC half period, 50 MHz in gives 1 MHz out
`define BOARD_RTC_HALF 25

// Steps in one fan PWM window
`define BOARD_FAN_STEPS 16

// Register map
`define BOARD_ADDR_ID       8'h00
`define BOARD_ADDR_RTC      8'h04
`define BOARD_ADDR_FAN_CTRL 8'h08
`define BOARD_ADDR_FAN_STAT 8'h0C

// Constant read values
`define BOARD_ID_VAL  32'h0B0A_7D01
`define BOARD_ERR_VAL 32'hBADC_AB1E

`endif

/* source/board_ctrl_pkg.sv */
package board_ctrl_pkg;

  ////////////////////////////////////////
  // Fan control
  ////////////////////////////////////////

  // Duty level in sixteenths of a PWM window
  // 0 keeps the fan off, 15 is the highest duty
  typedef logic [3:0] fan_level_t;

  ////////////////////////////////////////
  // Real-time clock
  ////////////////////////////////////////

  // RTC periods seen since reset
  // Wraps silently after 2^32 periods
  typedef logic [31:0] rtc_count_t;

endpackage

/* source/apb_if.sv */
`include "board_ctrl_defines.svh"

interface apb_if;

  // Request side
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`BOARD_APB_AW-1:0] paddr;
  logic [`BOARD_APB_DW-1:0] pwdata;

  // Response side
  logic [`BOARD_APB_DW-1:0] prdata;
  logic                     pready;
  logic                     pslverr;

  // Bus master view
  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // Register block view
  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

/* source/rtc_tick_gen.sv */
`include "board_ctrl_defines.svh"

module rtc_tick_gen
  import board_ctrl_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  output logic       rtc_clk_o,
  output rtc_count_t rtc_count_o
);

  logic [4:0] div_q;
  logic       rtc_clk_q;
  rtc_count_t count_q;
  logic       half_done;

  // Last cycle of an RTC half period
  assign half_done = (div_q == 5'(`BOARD_RTC_HALF - 1));

  ////////////////////////////////////////
  // Divider and period counter
  ////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      div_q     <= '0;
      rtc_clk_q <= 1'b0;
      count_q   <= '0;
    end else begin
      if (half_done) begin
        div_q     <= '0;
        rtc_clk_q <= ~rtc_clk_q;
        // Count on the rising edge of the RTC clock
        if (!rtc_clk_q) begin
          count_q <= count_q + 1'b1;
        end
      end else begin
        div_q <= div_q + 5'd1;
      end
    end
  end

  assign rtc_clk_o   = rtc_clk_q;
  assign rtc_count_o = count_q;

endmodule

/* source/fan_pwm.sv */
`include "board_ctrl_defines.svh"

module fan_pwm
  import board_ctrl_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  input  fan_level_t level_i,
  output logic       fan_pwm_o
);

  localparam logic [3:0] LastStep = 4'(`BOARD_FAN_STEPS - 1);

  logic [3:0] step_q, step_d;
  fan_level_t level_q, level_d;
  logic       pwm_q, pwm_d;

  // Step and level for the next output cycle
  always_comb begin
    step_d  = (step_q == LastStep) ? 4'd0 : step_q + 4'd1;
    level_d = level_q;
    // New window, take the current setting
    if (step_d == 4'd0) begin
      level_d = level_i;
    end
    pwm_d = (step_d < level_d);
  end

  ////////////////////////////////////////
  // Window state
  ////////////////////////////////////////

  // step_q is the step currently shown on fan_pwm_o
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      step_q  <= LastStep;
      level_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      step_q  <= step_d;
      level_q <= level_d;
      pwm_q   <= pwm_d;
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

/* source/board_regs.sv */
`include "board_ctrl_defines.svh"

module board_regs
  import board_ctrl_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  apb_if.completer   apb,
  input  rtc_count_t rtc_count_i,
  input  fan_level_t fan_sw_i,
  output fan_level_t fan_level_o
);

  logic       access;
  logic       hit_id;
  logic       hit_rtc;
  logic       hit_ctrl;
  logic       hit_stat;
  logic       mapped;
  logic       ctrl_wr;

  // FAN_CTRL fields
  logic       ovr_en_q;
  fan_level_t ovr_level_q;

  fan_level_t fan_level_q;
  logic [`BOARD_APB_DW-1:0] rdata;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Access cycle of an APB transfer
  assign access = apb.psel & apb.penable;

  assign hit_id   = (apb.paddr == `BOARD_ADDR_ID);
  assign hit_rtc  = (apb.paddr == `BOARD_ADDR_RTC);
  assign hit_ctrl = (apb.paddr == `BOARD_ADDR_FAN_CTRL);
  assign hit_stat = (apb.paddr == `BOARD_ADDR_FAN_STAT);
  assign mapped   = hit_id | hit_rtc | hit_ctrl | hit_stat;

  // FAN_CTRL is the only writable register
  assign ctrl_wr = access & apb.pwrite & hit_ctrl;

  ////////////////////////////////////////
  // Fan control register
  ////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      ovr_en_q    <= 1'b0;
      ovr_level_q <= '0;
    end else if (ctrl_wr) begin
      ovr_en_q    <= apb.pwdata[4];
      ovr_level_q <= apb.pwdata[3:0];
    end
  end

  // Effective level, one cycle behind the control register
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      fan_level_q <= '0;
    end else begin
      fan_level_q <= ovr_en_q ? ovr_level_q : fan_sw_i;
    end
  end

  assign fan_level_o = fan_level_q;

  ////////////////////////////////////////
  // Read path and response
  ////////////////////////////////////////

  always_comb begin
    rdata = '0;
    unique case (1'b1)
      hit_id: begin
        rdata = `BOARD_ID_VAL;
      end
      hit_rtc: begin
        rdata = rtc_count_i;
      end
      hit_ctrl: begin
        rdata[4]   = ovr_en_q;
        rdata[3:0] = ovr_level_q;
      end
      hit_stat: begin
        rdata[3:0] = fan_level_q;
      end
      default: begin
        rdata = `BOARD_ERR_VAL;
      end
    endcase
  end

  // No wait states, every access cycle completes
  assign apb.pready = access;
  assign apb.prdata = rdata;

  // Reads fail on holes, writes fail anywhere but FAN_CTRL
  assign apb.pslverr = access & (apb.pwrite ? ~hit_ctrl : ~mapped);

endmodule

/* source/board_ctrl_top.sv */
`include "board_ctrl_defines.svh"

module board_ctrl_top
  import board_ctrl_pkg::*;
(
  input  logic                     soc_clk,
  input  logic                     rst_n,

  input  logic [3:0]               fan_sw_i,
  output logic                     fan_pwm_o,

  output logic                     rtc_clk_o,

  // APB register port
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`BOARD_APB_AW-1:0] paddr_i,
  input  logic [`BOARD_APB_DW-1:0] pwdata_i,
  output logic [`BOARD_APB_DW-1:0] prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o
);

  rtc_count_t rtc_count;
  fan_level_t fan_level;

  apb_if apb_bus ();

  // Outside bus onto the internal APB
  assign apb_bus.psel    = psel_i;
  assign apb_bus.penable = penable_i;
  assign apb_bus.pwrite  = pwrite_i;
  assign apb_bus.paddr   = paddr_i;
  assign apb_bus.pwdata  = pwdata_i;

  assign prdata_o  = apb_bus.prdata;
  assign pready_o  = apb_bus.pready;
  assign pslverr_o = apb_bus.pslverr;

  ////////////////////////////////////////
  // RTC clock
  ////////////////////////////////////////

  rtc_tick_gen i_rtc_tick_gen (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .rtc_clk_o   ( rtc_clk_o ),
    .rtc_count_o ( rtc_count )
  );

  ////////////////////////////////////////
  // Fan PWM
  ////////////////////////////////////////

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .level_i   ( fan_level ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  board_regs i_board_regs (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .apb         ( apb_bus   ),
    .rtc_count_i ( rtc_count ),
    .fan_sw_i    ( fan_sw_i  ),
    .fan_level_o ( fan_level )
  );

endmodule

/* verification/board_ctrl_assertions.sv */
module board_ctrl_assertions (
  input logic soc_clk,
  input logic rst_n,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic rtc_clk_i
);

  logic [5:0] since_rst;
  logic       rtc_seen;

  // Cycles from reset release to the first RTC edge
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      since_rst <= '0;
      rtc_seen  <= 1'b0;
    end else begin
      if (!rtc_seen) begin
        since_rst <= since_rst + 6'd1;
      end
      if (rtc_clk_i) begin
        rtc_seen <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // APB response
  ////////////////////////////////////////

  err_in_access: assert property (@(posedge soc_clk) disable iff (!rst_n)
    pslverr_i |-> (psel_i && penable_i))
    else $error("pslverr_o high outside an access cycle");

  ready_in_access: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (psel_i && penable_i) |-> pready_i)
    else $error("pready_o low in an access cycle");

  rtc_starts: assert property (@(posedge soc_clk) disable iff (!rst_n)
    !rtc_seen |-> (since_rst <= 6'd26))
    else $error("rtc_clk_o did not change within 26 cycles of reset");

endmodule

bind board_ctrl_top board_ctrl_assertions i_board_ctrl_assertions (
  .soc_clk   ( soc_clk   ),
  .rst_n     ( rst_n     ),
  .psel_i    ( psel_i    ),
  .penable_i ( penable_i ),
  .pready_i  ( pready_o  ),
  .pslverr_i ( pslverr_o ),
  .rtc_clk_i ( rtc_clk_o )
);

/* verification/tb_board_ctrl.sv */
`include "board_ctrl_defines.svh"

module tb_board_ctrl;

  logic                     soc_clk;
  logic                     rst_n;
  logic [3:0]               fan_sw;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`BOARD_APB_AW-1:0] paddr;
  logic [`BOARD_APB_DW-1:0] pwdata;
  logic [`BOARD_APB_DW-1:0] prdata;
  logic                     pready;
  logic                     pslverr;
  logic                     fan_pwm;
  logic                     rtc_clk;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle = 0;
  int          xfer_cycle = 0;
  int          errs_before;
  logic [31:0] rng_state;

  board_ctrl_top UUT (
    .soc_clk   ( soc_clk ),
    .rst_n     ( rst_n   ),
    .fan_sw_i  ( fan_sw  ),
    .fan_pwm_o ( fan_pwm ),
    .rtc_clk_o ( rtc_clk ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .prdata_o  ( prdata  ),
    .pready_o  ( pready  ),
    .pslverr_o ( pslverr )
  );

  always #10 soc_clk = ~soc_clk;

  always @(posedge soc_clk) cycle <= cycle + 1;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  // Setup cycle, then access cycle until pready
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waited;
    @(negedge soc_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge soc_clk);
    penable = 1'b1;
    waited  = 0;
    do begin
      @(posedge soc_clk);
      waited++;
    end while (!pready && waited < 8);
    rdata      = prdata;
    err        = pslverr;
    xfer_cycle = cycle;
    assert (pready) else begin
      $display("APB transfer to %h got no pready within 8 cycles", addr);
      errors++;
    end
    @(negedge soc_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // High cycles in one window, counted from a rising edge
  task automatic check_pwm_level(input logic [3:0] level);
    int   waited;
    int   high;
    logic prev;
    high   = 0;
    waited = 0;
    prev   = 1'b1;
    if (level != 4'd0) begin
      do begin
        prev = fan_pwm;
        @(negedge soc_clk);
        waited++;
      end while (!(fan_pwm && !prev) && waited < 40);
      assert (fan_pwm && !prev) else begin
        $display("fan_pwm_o showed no rising edge within 40 cycles");
        errors++;
      end
    end
    repeat ((level == 4'd0) ? 32 : 16) begin
      if (fan_pwm) high++;
      @(negedge soc_clk);
    end
    check_value("fan_pwm_o high cycles", 32'(high), 32'(level));
  endtask

  task automatic wait_rtc_toggle(output int cycles);
    logic start;
    start  = rtc_clk;
    cycles = 0;
    do begin
      @(negedge soc_clk);
      cycles++;
    end while (rtc_clk == start && cycles < 60);
    assert (rtc_clk != start) else begin
      $display("rtc_clk_o did not toggle within 60 cycles");
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_register_file();
    int          fd;
    int          fields;
    int          line_no;
    string       line;
    logic [7:0]  op;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [31:0] rdata;
    logic        err;
    line_no = 0;
    fd = $fopen("verification/board_ctrl_testdata.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the register test data file");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      // Skip blank and comment lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, exp_rdata, exp_err);
        assert (fields == 5) else begin
          $display("Test data line %0d could not be parsed", line_no);
          errors++;
        end
        if (fields == 5) begin
          apb_xfer(op == "w", addr, wdata, rdata, err);
          if (op == "r") begin
            check_value($sformatf("prdata_o at %h", addr), rdata, exp_rdata);
          end
          check_value($sformatf("pslverr_o at %h", addr), 32'(err), 32'(exp_err));
        end
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  task automatic run_fan_levels(input logic use_override);
    logic [31:0] rdata;
    logic        err;
    logic [3:0]  ovr_level;
    logic [3:0]  level;
    for (int i = 0; i < 5; i++) begin
      rng_state = next_random(rng_state);
      @(negedge soc_clk);
      fan_sw = (i == 4 && !use_override) ? 4'd0 : rng_state[3:0];
      // Override level always differs from the switches
      ovr_level = fan_sw + 4'd7;
      level     = use_override ? ovr_level : fan_sw;
      apb_xfer(1'b1, `BOARD_ADDR_FAN_CTRL, {27'd0, use_override, ovr_level}, rdata, err);
      check_value("pslverr_o on FAN_CTRL write", 32'(err), 32'd0);
      repeat (32) @(negedge soc_clk);
      check_pwm_level(level);
      apb_xfer(1'b0, `BOARD_ADDR_FAN_STAT, 32'd0, rdata, err);
      check_value("FAN_STAT prdata_o", rdata, 32'(level));
    end
  endtask

  task automatic run_rtc();
    int          half;
    int          c0;
    int          expect_delta;
    logic [31:0] r0;
    logic [31:0] r1;
    logic        err;
    wait_rtc_toggle(half);
    repeat (4) begin
      wait_rtc_toggle(half);
      check_value("rtc_clk_o half period", 32'(half), 32'd25);
    end
    apb_xfer(1'b0, `BOARD_ADDR_RTC, 32'd0, r0, err);
    c0 = xfer_cycle;
    repeat (500) @(negedge soc_clk);
    apb_xfer(1'b0, `BOARD_ADDR_RTC, 32'd0, r1, err);
    expect_delta = (xfer_cycle - c0) / 50;
    assert (int'(r1 - r0) >= expect_delta - 1 && int'(r1 - r0) <= expect_delta + 1) else begin
      $display("error: RTC count delta got %h expected %h", r1 - r0, expect_delta);
      errors++;
    end
    // A write to RTC must leave the count running
    apb_xfer(1'b1, `BOARD_ADDR_RTC, 32'd0, r0, err);
    check_value("pslverr_o on RTC write", 32'(err), 32'd1);
    apb_xfer(1'b0, `BOARD_ADDR_RTC, 32'd0, r0, err);
    assert (r0 >= r1) else begin
      $display("error: RTC prdata_o %h below earlier %h", r0, r1);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    soc_clk   = 1'b0;
    rst_n     = 1'b0;
    fan_sw    = 4'd0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    rng_state = 32'd91221;

    errs_before = errors;
    repeat (3) @(negedge soc_clk);
    check_value("fan_pwm_o in reset", 32'(fan_pwm), 32'd0);
    check_value("rtc_clk_o in reset", 32'(rtc_clk), 32'd0);
    check_value("pready_o in reset", 32'(pready), 32'd0);
    rst_n = 1'b1;
    report_test("reset");

    errs_before = errors;
    run_register_file();
    report_test("registers");

    errs_before = errors;
    run_fan_levels(1'b0);
    report_test("fan switches");

    errs_before = errors;
    run_fan_levels(1'b1);
    run_fan_levels(1'b0);
    report_test("fan override");

    errs_before = errors;
    run_rtc();
    report_test("rtc");

    $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verification/board_ctrl_testdata.txt */
# op addr wdata expected_rdata expected_pslverr, all numbers in hex
# op r reads, op w writes; expected_rdata is only compared on reads
r 00 00000000 0B0A7D01 0
r 08 00000000 00000000 0
r 0C 00000000 00000000 0
r 10 00000000 BADCAB1E 1
r 02 00000000 BADCAB1E 1
r FC 00000000 BADCAB1E 1
w 00 12345678 00000000 1
r 00 00000000 0B0A7D01 0
w 04 00000000 00000000 1
w 0C 0000000F 00000000 1
r 0C 00000000 00000000 0
w 40 FFFFFFFF 00000000 1
r 08 00000000 00000000 0
w 08 0000001A 00000000 0
r 08 00000000 0000001A 0
r 0C 00000000 0000000A 0
w 08 FFFFFFE5 00000000 0
r 08 00000000 00000005 0
r 0C 00000000 00000000 0
w 08 00000000 00000000 0
r 08 00000000 00000000 0

/* verilog.f */
+incdir+source
source/board_ctrl_pkg.sv
source/apb_if.sv
source/rtc_tick_gen.sv
source/fan_pwm.sv
source/board_regs.sv
source/board_ctrl_top.sv
verification/board_ctrl_assertions.sv
verification/tb_board_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the board control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_board_ctrl \
    -o sim_board_ctrl \
  && out="$(./obj_dir/sim_board_ctrl)" \
  && echo "$out" \
  && grep -q "All checks passed" <<< "$out" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

exit 0
